// ==== mmu_top.f ====
hw/mmu_pkg.sv
hw/wb_pkg.sv
hw/sv32_tlb.sv
hw/page_walker.sv
hw/mmu_top.sv
sim/mmu_asserts.sv
sim/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu_top

sources:
  - files:
      - hw/mmu_pkg.sv
      - hw/wb_pkg.sv
      - hw/sv32_tlb.sv
      - hw/page_walker.sv
      - hw/mmu_top.sv
  - target: simulation
    files:
      - sim/mmu_asserts.sv
      - sim/mmu_tb.sv

// ==== sim/mmu_tb.sv ====
// Testbench for the Sv32 MMU top level
// Page tables live in a sparse PTE memory with random ack delay. Directed and
// random translations are checked against a reference walk of the same tables
`timescale 1ns/100ps

module mmu_tb;
    import mmu_pkg::*;
    import wb_pkg::*;

    localparam int          N_DIRECTED = 26;
    localparam int          N_RANDOM   = 40;
    localparam int          N_REQ      = N_DIRECTED + N_RANDOM;
    localparam logic [31:0] SEED       = 32'hdfd5_9632;
    localparam logic [21:0] ROOT       = 22'h00100;
    localparam logic [21:0] L0_TABLE   = 22'h00101;

    // pte flag bits
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;

    typedef struct packed {
        logic                fault;
        logic [PA_WIDTH-1:0] pa;
    } xlate_t;

    logic       clk;
    logic       nRST;
    csr_state_t csr;
    logic       flush;
    xl_req_t    ireq;
    xl_rsp_t    irsp;
    xl_req_t    dreq;
    xl_rsp_t    drsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    logic [31:0] pt_mem [logic [PA_WIDTH-1:0]];   // sparse memory where absent words read as 0
    int          mem_reads = 0;
    xlate_t      iexp [$];
    xlate_t      dexp [$];

    mmu_top mmu_top_i (
        .clk     (clk),
        .nRST    (nRST),
        .csr     (csr),
        .flush   (flush),
        .ireq    (ireq),
        .irsp    (irsp),
        .dreq    (dreq),
        .drsp    (drsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] read_pte(input logic [PA_WIDTH-1:0] a);
        return pt_mem.exists(a) ? pt_mem[a] : 32'h0;
    endfunction

    function automatic logic [31:0] make_va(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                            input logic [11:0] off);
        return {vpn1, vpn0, off};
    endfunction

    // expected result from the Sv32 rules over at most two levels
    function automatic xlate_t translate_ref(input logic [31:0] va, input logic store,
                                             input logic fetch, input csr_state_t c);
        xlate_t      res;
        pte_t        pte;
        logic [21:0] ppn;
        logic        perm_ok;
        res = '0;
        if (c.mode != 1'b1 || c.priv == M_MODE) begin
            res.pa = {2'b00, va};   // bare
            return res;
        end
        pte = read_pte({c.root_ppn, va[31:22], 2'b00});
        if (pte.perms.v && !pte.perms.r && !pte.perms.w && !pte.perms.x) begin
            pte = read_pte({pte.ppn, va[21:12], 2'b00});
            if (pte.perms.v && !pte.perms.r && !pte.perms.w && !pte.perms.x) begin
                res.fault = 1'b1;   // still a pointer at the last level
            end
            ppn = pte.ppn;
        end else begin
            if (pte.ppn[9:0] != 10'd0) begin
                res.fault = 1'b1;   // megapage not aligned
            end
            ppn = {pte.ppn[21:10], va[21:12]};
        end
        if (!pte.perms.v || (pte.perms.w && !pte.perms.r)) begin
            res.fault = 1'b1;
        end
        if (fetch) begin
            perm_ok = pte.perms.x;
        end else begin
            perm_ok = store ? pte.perms.w : pte.perms.r;
        end
        if (c.priv == U_MODE && !pte.perms.u) perm_ok = 1'b0;
        if (c.priv == S_MODE && pte.perms.u && !c.sum) perm_ok = 1'b0;
        res.fault = res.fault || !perm_ok;
        res.pa    = res.fault ? '0 : {ppn, va[11:0]};
        return res;
    endfunction

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch, run stopped");
        end
    endtask

    task automatic put_pte(input logic [21:0] tbl, input logic [9:0] idx,
                           input logic [21:0] ppn, input logic [7:0] flags);
        pt_mem[{tbl, idx, 2'b00}] = {ppn, 2'b00, flags};
    endtask

    task automatic setup_tables();
        put_pte(ROOT, 10'd1, L0_TABLE, F_V);                    // pointer
        put_pte(ROOT, 10'd2, 22'h00400, F_V | F_R | F_W | F_X);  // aligned megapage
        put_pte(ROOT, 10'd3, 22'h00401, F_V | F_R | F_W);        // misaligned
        put_pte(L0_TABLE, 10'd0, 22'h00200, F_V | F_R | F_W | F_X);
        put_pte(L0_TABLE, 10'd1, 22'h00201, F_V | F_R);          // read-only
        put_pte(L0_TABLE, 10'd2, 22'h00202, F_V | F_R | F_W);    // no x
        put_pte(L0_TABLE, 10'd4, 22'h00204, F_V | F_W);          // w without r
        put_pte(L0_TABLE, 10'd5, 22'h00205, F_V);                // pointer at level 0
        put_pte(L0_TABLE, 10'd6, 22'h00206, F_V | F_R | F_W | F_X | F_U);
        put_pte(L0_TABLE, 10'd7, 22'h00207, F_V | F_R | F_W);
    endtask

    task automatic set_csr(input logic mode, input priv_t priv, input logic sum);
        csr = '{mode: mode, root_ppn: ROOT, priv: priv, sum: sum};
    endtask

    task automatic flush_tlbs();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // one Wishbone request issued 1 ns after a rising edge
    task automatic send_request(input logic dport, input logic [31:0] va, input logic store,
                                input xlate_t exp, output int cycles);
        xl_req_t r;
        logic    done;
        r = '{cyc: 1'b1, stb: 1'b1, we: store, adr: va};
        if (dport) begin
            dexp.push_back(exp);
            dreq = r;
        end else begin
            iexp.push_back(exp);
            ireq = r;
        end
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            cycles++;
            done = dport ? (drsp.ack || drsp.err) : (irsp.ack || irsp.err);
        end
        @(posedge clk);   // a clocked master sees the ack at this edge
        #1;
        if (dport) dreq = '0;
        else ireq = '0;
    endtask

    task automatic translate(input logic dport, input logic [31:0] va, input logic store,
                             output int cycles);
        send_request(dport, va, store, translate_ref(va, store, !dport, csr), cycles);
    endtask

    task automatic compare_rsp(input xl_rsp_t rsp, input xlate_t exp, input string port);
        check_eq(rsp.ack && rsp.err, 1'b0, {port, " ack and err together"});
        check_eq(rsp.err, exp.fault, {port, " fault"});
        if (!exp.fault) check_eq(rsp.dat, exp.pa, {port, " physical address"});
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // PTE memory that acks after 0 to 3 wait cycles
    initial begin
        logic [PA_WIDTH-1:0] addr;
        logic [31:0]         seed;
        int                  wait_cycles;
        seed    = SEED;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            while (mem_req.cyc && mem_req.stb) begin
                addr        = mem_req.adr;
                seed        = lcg(seed);
                wait_cycles = seed[31:30];
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                mem_rsp.ack = 1'b1;
                mem_rsp.dat = read_pte(addr);
                mem_reads++;
                @(posedge clk);
                #1;
                mem_rsp.ack = 1'b0;
            end
        end
    end

    // responses are registered, so the middle of the cycle is stable
    initial begin
        forever begin
            @(negedge clk);
            if (irsp.ack || irsp.err) begin
                check_eq(iexp.size() > 0, 1'b1, "fetch port answered with nothing pending");
                compare_rsp(irsp, iexp.pop_front(), "fetch port");
            end
            if (drsp.ack || drsp.err) begin
                check_eq(dexp.size() > 0, 1'b1, "data port answered with nothing pending");
                compare_rsp(drsp, dexp.pop_front(), "data port");
            end
        end
    end

    initial begin
        repeat (N_REQ * 40) @(posedge clk);
        $display("Timeout: the requests did not all complete within %0d cycles", N_REQ * 40);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          cyc;
        int          reads;
        logic [31:0] va;
        logic [31:0] seed;
        logic        dport;
        logic        store;
        xlate_t      old_exp;
        nRST  = 1'b0;
        flush = 1'b0;
        ireq  = '0;
        dreq  = '0;
        set_csr(1'b1, M_MODE, 1'b0);
        setup_tables();
        repeat (3) @(posedge clk);
        #1;
        nRST = 1'b1;

        // bare mode in M-mode and then in S-mode with satp mode 0
        reads = mem_reads;
        translate(1'b0, 32'h1234_5678, 1'b0, cyc);
        translate(1'b1, 32'hfedc_ba98, 1'b0, cyc);
        translate(1'b1, 32'h8000_0004, 1'b1, cyc);
        set_csr(1'b0, S_MODE, 1'b0);
        translate(1'b0, 32'h0040_1000, 1'b0, cyc);
        translate(1'b1, 32'h0040_2000, 1'b1, cyc);
        check_eq(mem_reads, reads, "memory reads in bare mode");

        // 4 KiB pages with a miss and then a hit
        set_csr(1'b1, S_MODE, 1'b0);
        translate(1'b1, make_va(10'd1, 10'd0, 12'h010), 1'b0, cyc);
        translate(1'b1, make_va(10'd1, 10'd0, 12'h020), 1'b0, cyc);
        check_eq(cyc, 1, "data hit latency");
        translate(1'b1, make_va(10'd1, 10'd0, 12'h024), 1'b1, cyc);
        translate(1'b0, make_va(10'd1, 10'd0, 12'h100), 1'b0, cyc);
        translate(1'b0, make_va(10'd1, 10'd0, 12'h104), 1'b0, cyc);
        check_eq(cyc, 1, "fetch hit latency");

        // megapages
        translate(1'b1, make_va(10'd2, 10'h155, 12'habc), 1'b0, cyc);
        translate(1'b0, make_va(10'd2, 10'h2aa, 12'h008), 1'b0, cyc);
        translate(1'b1, make_va(10'd3, 10'h001, 12'h000), 1'b0, cyc);

        // invalid, w without r, pointer at level 0
        translate(1'b1, make_va(10'd1, 10'd3, 12'h000), 1'b0, cyc);
        translate(1'b1, make_va(10'd1, 10'd4, 12'h000), 1'b0, cyc);
        translate(1'b1, make_va(10'd1, 10'd5, 12'h000), 1'b0, cyc);

        // permissions
        translate(1'b1, make_va(10'd1, 10'd1, 12'h040), 1'b1, cyc);
        translate(1'b0, make_va(10'd1, 10'd2, 12'h040), 1'b0, cyc);
        set_csr(1'b1, U_MODE, 1'b0);
        translate(1'b1, make_va(10'd1, 10'd0, 12'h040), 1'b0, cyc);
        set_csr(1'b1, S_MODE, 1'b0);
        translate(1'b1, make_va(10'd1, 10'd6, 12'h080), 1'b0, cyc);
        set_csr(1'b1, S_MODE, 1'b1);
        translate(1'b1, make_va(10'd1, 10'd6, 12'h080), 1'b0, cyc);

        // both ports miss together and the data walk goes first
        set_csr(1'b1, S_MODE, 1'b0);
        flush_tlbs();
        fork
            translate(1'b0, make_va(10'd2, 10'h011, 12'h200), 1'b0, cyc);
            translate(1'b1, make_va(10'd1, 10'd0, 12'h300), 1'b0, cyc);
        join

        // stale hit until the flush and the new mapping after it
        flush_tlbs();
        va = make_va(10'd1, 10'd7, 12'h0c0);
        translate(1'b1, va, 1'b0, cyc);
        old_exp = translate_ref(va, 1'b0, 1'b0, csr);
        put_pte(L0_TABLE, 10'd7, 22'h00307, F_V | F_R | F_W);
        send_request(1'b1, va, 1'b0, old_exp, cyc);
        flush_tlbs();
        translate(1'b1, va, 1'b0, cyc);

        // random mix
        seed = SEED;
        for (int n = 0; n < N_RANDOM; n++) begin
            seed  = lcg(seed);
            dport = seed[31];
            store = seed[30] && dport;
            set_csr(1'b1, seed[24] ? U_MODE : S_MODE, seed[23]);
            va = make_va(10'(seed[29:28]) + 10'd1, {7'd0, seed[27:25]}, seed[11:0]);
            translate(dport, va, store, cyc);
        end

        repeat (2) @(posedge clk);
        check_eq(iexp.size() + dexp.size(), 0, "responses still pending");
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim/mmu_asserts.sv ====
// Concurrent checks on the page walker's memory bus and done pulses
// Attached to every page_walker instance by the bind at the bottom
`timescale 1ns/100ps

module walker_asserts (
    input logic               clk,
    input logic               nRST,
    input wb_pkg::mem_req_t   mem_req,
    input wb_pkg::mem_rsp_t   mem_rsp,
    input mmu_pkg::walk_rsp_t iwalk_rsp,
    input mmu_pkg::walk_rsp_t dwalk_rsp
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!nRST)
        mem_req.stb |-> mem_req.cyc)
        else $error("walker raised mem stb without cyc");

    // classic cycle holds the request until ack
    adr_held: assert property (@(posedge clk) disable iff (!nRST)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr))
        else $error("walker changed or dropped its PTE read before ack");

    one_done: assert property (@(posedge clk) disable iff (!nRST)
        !(iwalk_rsp.done && dwalk_rsp.done))
        else $error("walker signalled done to both TLBs at once");

    idle_after_reset: assert property (@(posedge clk)
        !nRST |=> !mem_req.cyc)
        else $error("mem cyc high in the cycle after reset");

endmodule

bind page_walker walker_asserts walker_asserts_u (
    .clk       (clk),
    .nRST      (nRST),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .iwalk_rsp (iwalk_rsp),
    .dwalk_rsp (dwalk_rsp)
);

// ==== hw/mmu_top.sv ====
// Sv32 MMU top level
// Instruction and data TLBs on the two translation ports, sharing one
// page-table walker that owns the memory port
`timescale 1ns/100ps

module mmu_top (
    input  logic                clk,
    input  logic                nRST,
    input  mmu_pkg::csr_state_t csr,
    input  logic                flush,
    input  wb_pkg::xl_req_t     ireq,
    output wb_pkg::xl_rsp_t     irsp,
    input  wb_pkg::xl_req_t     dreq,
    output wb_pkg::xl_rsp_t     drsp,
    output wb_pkg::mem_req_t    mem_req,
    input  wb_pkg::mem_rsp_t    mem_rsp
);
    import mmu_pkg::*;

    walk_req_t iwalk_req;
    walk_req_t dwalk_req;
    walk_rsp_t iwalk_rsp;
    walk_rsp_t dwalk_rsp;

    sv32_tlb #(
        .IS_FETCH (1'b1)
    ) itlb_u (
        .clk      (clk),
        .nRST     (nRST),
        .csr      (csr),
        .flush    (flush),
        .req      (ireq),
        .rsp      (irsp),
        .walk_req (iwalk_req),
        .walk_rsp (iwalk_rsp)
    );

    sv32_tlb #(
        .IS_FETCH (1'b0)
    ) dtlb_u (
        .clk      (clk),
        .nRST     (nRST),
        .csr      (csr),
        .flush    (flush),
        .req      (dreq),
        .rsp      (drsp),
        .walk_req (dwalk_req),
        .walk_rsp (dwalk_rsp)
    );

    page_walker walker_u (
        .clk       (clk),
        .nRST      (nRST),
        .csr       (csr),
        .iwalk_req (iwalk_req),
        .dwalk_req (dwalk_req),
        .iwalk_rsp (iwalk_rsp),
        .dwalk_rsp (dwalk_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

// ==== hw/page_walker.sv ====
// Sv32 two-level page-table walker shared by the instruction and data TLBs
// Reads PTEs over a Wishbone classic master port, checks the table
// structure and returns the leaf with a done pulse to the requester
`timescale 1ns/100ps

module page_walker (
    input  logic                clk,
    input  logic                nRST,
    input  mmu_pkg::csr_state_t csr,
    input  mmu_pkg::walk_req_t  iwalk_req,
    input  mmu_pkg::walk_req_t  dwalk_req,
    output mmu_pkg::walk_rsp_t  iwalk_rsp,
    output mmu_pkg::walk_rsp_t  dwalk_rsp,
    output wb_pkg::mem_req_t    mem_req,
    input  wb_pkg::mem_rsp_t    mem_rsp
);
    import mmu_pkg::*;

    typedef enum logic {
        IDLE,
        WALK
    } walk_state_t;

    walk_state_t state;

    logic                level;      // 1 at the root table, 0 at the leaf table
    logic                serve_d;    // data TLB owns the current walk
    logic [PA_WIDTH-1:0] pte_addr;

    logic        start;
    logic        pick_d;
    logic [19:0] vpn_sel;
    logic [9:0]  vpn1;
    logic [9:0]  vpn0;

    pte_t pte;
    logic is_leaf;
    logic bad_pte;
    logic ptr_at_l0;
    logic misaligned;
    logic fault;
    logic step;
    logic finish;
    logic descend;
    pte_t leaf_fixed;

    assign start = dwalk_req.valid || iwalk_req.valid;

    // data side wins when both are waiting
    assign pick_d  = (state == IDLE) ? dwalk_req.valid : serve_d;
    assign vpn_sel = pick_d ? dwalk_req.vpn : iwalk_req.vpn;
    assign vpn1    = vpn_sel[19:10];
    assign vpn0    = vpn_sel[9:0];

    assign pte = mem_rsp.dat;

    // r or x set marks a leaf
    assign is_leaf = pte.perms.r || pte.perms.x;

    // structural checks on the PTE just read
    assign bad_pte    = !pte.perms.v || (pte.perms.w && !pte.perms.r);
    assign ptr_at_l0  = !level && !is_leaf;
    assign misaligned = level && is_leaf && (pte.ppn[9:0] != '0);
    assign fault      = bad_pte || ptr_at_l0 || misaligned;

    assign step    = (state == WALK) && mem_rsp.ack;
    assign finish  = step && (fault || is_leaf);
    assign descend = step && !finish;

    // low ppn of a megapage comes from the virtual address
    always_comb begin
        leaf_fixed = pte;
        if (level) begin
            leaf_fixed.ppn = {pte.ppn[21:10], vpn0};
        end
    end

    always_ff @(posedge clk) begin
        if (!nRST) begin
            state   <= IDLE;
            level   <= 1'b1;
            serve_d <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= WALK;
                        level   <= 1'b1;
                        serve_d <= dwalk_req.valid;
                    end
                end
                WALK: begin
                    if (finish) begin
                        state <= IDLE;
                    end else if (descend) begin
                        level <= 1'b0;   // pointer means one level down
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            pte_addr <= {csr.root_ppn, vpn1, 2'b00};
        end else if (descend) begin
            pte_addr <= {pte.ppn, vpn0, 2'b00};
        end
    end

    // bus held for the whole walk and the address moves only after an ack
    assign mem_req.cyc = (state == WALK);
    assign mem_req.stb = (state == WALK);
    assign mem_req.adr = pte_addr;

    assign iwalk_rsp.done  = finish && !serve_d;
    assign iwalk_rsp.fault = fault;
    assign iwalk_rsp.leaf  = leaf_fixed;

    assign dwalk_rsp.done  = finish && serve_d;
    assign dwalk_rsp.fault = fault;
    assign dwalk_rsp.leaf  = leaf_fixed;

endmodule

// ==== hw/sv32_tlb.sv ====
// Fully associative Sv32 TLB in front of one translation port
// Hits and bare-mode accesses answer one cycle after the request is sampled,
// misses go through the shared walker and are refilled round-robin
`timescale 1ns/100ps

module sv32_tlb #(
    parameter bit IS_FETCH = 1'b0   // 1 for the instruction port
) (
    input  logic                clk,
    input  logic                nRST,
    input  mmu_pkg::csr_state_t csr,
    input  logic                flush,
    input  wb_pkg::xl_req_t     req,
    output wb_pkg::xl_rsp_t     rsp,
    output mmu_pkg::walk_req_t  walk_req,
    input  mmu_pkg::walk_rsp_t  walk_rsp
);
    import mmu_pkg::*;

    typedef enum logic {
        LOOKUP,
        REFILL
    } tlb_state_t;

    tlb_state_t state;

    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [19:0]            ent_vpn [TLB_ENTRIES];
    pte_t                   ent_pte [TLB_ENTRIES];
    logic [TLB_IDX_W-1:0]   fill_ptr;

    va_t  va_q;     // request captured on a miss
    logic we_q;

    logic                rsp_ack;
    logic                rsp_err;
    logic [PA_WIDTH-1:0] rsp_dat;

    va_t  va;
    logic xlate_on;
    logic accept;
    logic hit;
    pte_t hit_pte;
    logic hit_ok;
    logic fill_done;
    logic fill_ok;

    // rights for this port plus the U/SUM rule
    function automatic logic access_ok(pte_perms_t p, logic store, csr_state_t c);
        logic rights;
        logic mode_ok;
        rights  = IS_FETCH ? p.x : (store ? p.w : p.r);
        mode_ok = (c.priv == U_MODE) ? p.u : (!p.u || c.sum);
        return rights && mode_ok;
    endfunction

    assign va       = req.adr;
    assign xlate_on = (csr.mode == SATP_MODE_SV32) &&
                      (csr.priv == S_MODE || csr.priv == U_MODE);

    // no new request while the previous one is being acked
    assign accept = (state == LOOKUP) && req.cyc && req.stb && !(rsp_ack || rsp_err);

    always_comb begin
        hit     = 1'b0;
        hit_pte = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_valid[i] && ent_vpn[i] == {va.vpn1, va.vpn0}) begin
                hit     = 1'b1;
                hit_pte = ent_pte[i];
            end
        end
    end

    assign hit_ok    = access_ok(hit_pte.perms, req.we, csr);
    assign fill_done = (state == REFILL) && walk_rsp.done;
    assign fill_ok   = access_ok(walk_rsp.leaf.perms, we_q, csr);

    always_ff @(posedge clk) begin
        if (!nRST) begin
            state     <= LOOKUP;
            ent_valid <= '0;
            fill_ptr  <= '0;
            rsp_ack   <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_ack <= 1'b0;   // single-cycle pulses
            rsp_err <= 1'b0;
            case (state)
                LOOKUP: begin
                    if (accept) begin
                        if (!xlate_on) begin
                            rsp_ack <= 1'b1;
                        end else if (hit) begin
                            rsp_ack <= hit_ok;
                            rsp_err <= !hit_ok;
                        end else begin
                            state <= REFILL;
                        end
                    end
                end
                REFILL: begin
                    if (walk_rsp.done) begin
                        state <= LOOKUP;
                        if (walk_rsp.fault) begin
                            rsp_err <= 1'b1;   // faulting walks are not cached
                        end else begin
                            rsp_ack             <= fill_ok;
                            rsp_err             <= !fill_ok;
                            ent_valid[fill_ptr] <= 1'b1;
                            fill_ptr <= (fill_ptr == TLB_IDX_W'(TLB_ENTRIES - 1)) ?
                                        '0 : fill_ptr + 1'b1;
                        end
                    end
                end
                default: state <= LOOKUP;
            endcase
            if (flush) begin
                ent_valid <= '0;   // sfence.vma
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            va_q    <= va;
            we_q    <= req.we;
            rsp_dat <= xlate_on ? {hit_pte.ppn, va.offset} : {2'b00, req.adr};
        end else if (fill_done) begin
            rsp_dat <= {walk_rsp.leaf.ppn, va_q.offset};
        end
        if (fill_done && !walk_rsp.fault) begin
            ent_vpn[fill_ptr] <= {va_q.vpn1, va_q.vpn0};
            ent_pte[fill_ptr] <= walk_rsp.leaf;
        end
    end

    assign walk_req.valid = (state == REFILL);
    assign walk_req.vpn   = {va_q.vpn1, va_q.vpn0};

    assign rsp.ack = rsp_ack;
    assign rsp.err = rsp_err;
    assign rsp.dat = rsp_dat;

endmodule

// ==== hw/wb_pkg.sv ====
// Wishbone classic structs for the two translation ports and the
// PTE read port of the walker
package wb_pkg;

    // translation port, core side is master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;       // store, data port only
        logic [31:0] adr;      // virtual address
    } xl_req_t;

    typedef struct packed {
        logic                         ack;
        logic                         err;   // page fault
        logic [mmu_pkg::PA_WIDTH-1:0] dat;   // physical address
    } xl_rsp_t;

    // PTE reads only, so no we or write data
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic [mmu_pkg::PA_WIDTH-1:0] adr;
    } mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } mem_rsp_t;

endpackage

// ==== hw/mmu_pkg.sv ====
// Sv32 paging types shared by the TLBs and the page-table walker
// Also holds the CSR view that the core drives into the MMU and the
// request and response structs of the TLB-to-walker link
package mmu_pkg;

    localparam int TLB_ENTRIES = 4;            // per TLB, fully associative
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    localparam int PA_WIDTH    = 34;           // Sv32 physical address

    localparam logic SATP_MODE_SV32 = 1'b1;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_t;

    // satp fields, current privilege and sstatus.SUM
    typedef struct packed {
        logic        mode;      // 1 selects Sv32, 0 is bare
        logic [21:0] root_ppn;
        priv_t       priv;
        logic        sum;       // S-mode may touch U pages
    } csr_state_t;

    typedef struct packed {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_perms_t;

    typedef struct packed {
        logic [21:0] ppn;
        pte_perms_t  perms;
    } pte_t;

    typedef struct packed {
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        logic [11:0] offset;
    } va_t;

    // held by the TLB until done comes back
    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
    } walk_req_t;

    // done is a single-cycle pulse; fault and leaf are valid with it
    typedef struct packed {
        logic done;
        logic fault;
        pte_t leaf;    // megapage ppn already filled from vpn0
    } walk_rsp_t;

endpackage
